// File: hdl/wb_periph_pkg.sv
//--------------------------------------------------------------------
// Shared map and types of the Wishbone peripheral subsystem
// Slave field is address bits 31..29; registers are word aligned
// Timer at 0x6000_0000, PWM at 0x8000_0000 under this decoding
//--------------------------------------------------------------------

package wb_periph_pkg;

	//----------------------------------------------------------------
	// Address map
	//----------------------------------------------------------------
	localparam int SLAVE_ADDR_W = 3;
	localparam logic [SLAVE_ADDR_W-1:0] TIMER_SLAVE = 3'b011;
	localparam logic [SLAVE_ADDR_W-1:0] PWM_SLAVE   = 3'b100;

	// Register index sits in address bits 3..2
	localparam int REG_ADDR_W = 2;

	localparam int PWM_CHANNELS = 8;
	localparam int DUTY_W       = 8;

	// PWM register indices
	localparam logic [REG_ADDR_W-1:0] PWM_CTRL    = 2'd0;
	localparam logic [REG_ADDR_W-1:0] PWM_DUTY_LO = 2'd1;
	localparam logic [REG_ADDR_W-1:0] PWM_DUTY_HI = 2'd2;
	localparam logic [REG_ADDR_W-1:0] PWM_COUNT   = 2'd3;

	// Timer register indices
	localparam logic [REG_ADDR_W-1:0] TMR_CTRL   = 2'd0;
	localparam logic [REG_ADDR_W-1:0] TMR_CMP    = 2'd1;
	localparam logic [REG_ADDR_W-1:0] TMR_COUNT  = 2'd2;
	localparam logic [REG_ADDR_W-1:0] TMR_STATUS = 2'd3;

	//----------------------------------------------------------------
	// Types
	//----------------------------------------------------------------
	typedef struct packed {
		logic [31:0] adr;
		logic [31:0] dat;
		logic [3:0]  sel;
		logic        we;
	} wb_req_t;

	typedef struct packed {
		logic [31:0] dat;
		logic        valid;
	} wb_rsp_t;

	// Enable mask in the low byte, prescaler above it
	typedef struct packed {
		logic [7:0]              rsvd;
		logic [15:0]             prescale;
		logic [PWM_CHANNELS-1:0] enable;
	} pwm_ctrl_t;

	// Channel 0 in byte 0
	typedef struct packed {
		logic [3:0][DUTY_W-1:0] duty;
	} pwm_duty_t;

	typedef union packed {
		pwm_ctrl_t ctrl;
		pwm_duty_t duty;
	} pwm_word_u;

	// Replace the bytes of old_w enabled in sel with those of new_w
	function automatic logic [31:0] byte_merge(logic [31:0] old_w, logic [31:0] new_w,
		logic [3:0] sel);
		logic [31:0] res;
		for (int b = 0; b < 4; b++) begin
			res[b*8 +: 8] = sel[b] ? new_w[b*8 +: 8] : old_w[b*8 +: 8];
		end
		return res;
	endfunction

endpackage

// File: hdl/wb_decoder.sv
//--------------------------------------------------------------------
// Decode stage. Takes each classic Wishbone cycle once, even though
// the master keeps stb high until ack. Busy clears when stb drops.
//--------------------------------------------------------------------

module wb_decoder (
	input  logic                  clk,
	input  logic                  rst_n_i,
	input  logic                  wb_cyc_i,
	input  logic                  wb_stb_i,
	input  logic                  wb_we_i,
	input  logic [31:0]           wb_adr_i,
	input  logic [31:0]           wb_dat_i,
	input  logic [3:0]            wb_sel_i,
	output wb_periph_pkg::wb_req_t req_o,
	output logic                  pwm_req_o,
	output logic                  tmr_req_o,
	output logic                  unmapped_o
);
	import wb_periph_pkg::*;

	logic                    busy;
	logic                    accept;
	logic [SLAVE_ADDR_W-1:0] slave;
	logic                    hit_pwm;
	logic                    hit_tmr;

	assign accept  = wb_cyc_i && wb_stb_i && !busy;
	assign slave   = wb_adr_i[31 -: SLAVE_ADDR_W];
	assign hit_pwm = (slave == PWM_SLAVE);
	assign hit_tmr = (slave == TIMER_SLAVE);

	// One-cycle request pulses
	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			busy       <= 1'b0;
			pwm_req_o  <= 1'b0;
			tmr_req_o  <= 1'b0;
			unmapped_o <= 1'b0;
		end else begin
			pwm_req_o  <= accept && hit_pwm;
			tmr_req_o  <= accept && hit_tmr;
			unmapped_o <= accept && !hit_pwm && !hit_tmr;
			if (accept) begin
				busy <= 1'b1;
			end else if (!wb_stb_i) begin
				busy <= 1'b0;
			end
		end
	end

	// Captured request
	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			req_o <= '0;
		end else if (accept) begin
			req_o <= '{adr: wb_adr_i, dat: wb_dat_i, sel: wb_sel_i, we: wb_we_i};
		end
	end

endmodule

// File: hdl/wb_pwm.sv
//--------------------------------------------------------------------
// Eight-channel PWM motor controller
// Counter steps once every prescale+1 cycles and wraps at 256.
// Counter register is read-only; writes to it are dropped.
//--------------------------------------------------------------------

module wb_pwm (
	input  logic                                    clk,
	input  logic                                    rst_n_i,
	input  wb_periph_pkg::wb_req_t                  req_i,
	input  logic                                    sel_i,
	output wb_periph_pkg::wb_rsp_t                  rsp_o,
	output logic [wb_periph_pkg::PWM_CHANNELS-1:0]  pwm_o
);
	import wb_periph_pkg::*;

	pwm_ctrl_t                          ctrl;
	pwm_duty_t                          duty_lo;
	pwm_duty_t                          duty_hi;
	logic [PWM_CHANNELS-1:0][DUTY_W-1:0] duty;
	logic [15:0]                        pre_cnt;
	logic [DUTY_W-1:0]                  count;
	logic [REG_ADDR_W-1:0]              idx;
	logic                               wr;
	pwm_word_u                          cur_word;
	pwm_word_u                          new_word;

	assign idx  = req_i.adr[REG_ADDR_W+1:2];
	assign wr   = sel_i && req_i.we;
	assign duty = {duty_hi.duty, duty_lo.duty};

	// Current value of the addressed register
	always_comb begin
		case (idx)
			PWM_CTRL:    cur_word.ctrl = ctrl;
			PWM_DUTY_LO: cur_word.duty = duty_lo;
			PWM_DUTY_HI: cur_word.duty = duty_hi;
			default:     cur_word = {{(32-DUTY_W){1'b0}}, count};
		endcase
	end

	assign new_word = byte_merge(cur_word, req_i.dat, req_i.sel);

	//----------------------------------------------------------------
	// Register writes
	//----------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			ctrl    <= '0;
			duty_lo <= '0;
			duty_hi <= '0;
		end else if (wr) begin
			case (idx)
				PWM_CTRL: begin
					// Reserved byte always reads back as zero
					ctrl <= '{rsvd: '0, prescale: new_word.ctrl.prescale,
						enable: new_word.ctrl.enable};
				end
				PWM_DUTY_LO: duty_lo <= new_word.duty;
				PWM_DUTY_HI: duty_hi <= new_word.duty;
				default: ;
			endcase
		end
	end

	//----------------------------------------------------------------
	// Prescaler, counter and compare outputs
	//----------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			pre_cnt <= '0;
			count   <= '0;
			pwm_o   <= '0;
		end else begin
			// >= so a smaller prescale written mid-count still wraps
			if (pre_cnt >= ctrl.prescale) begin
				pre_cnt <= '0;
				count   <= count + 1'b1;
			end else begin
				pre_cnt <= pre_cnt + 1'b1;
			end
			for (int k = 0; k < PWM_CHANNELS; k++) begin
				pwm_o[k] <= ctrl.enable[k] && (count < duty[k]);
			end
		end
	end

	// Response one cycle after the request
	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			rsp_o <= '0;
		end else begin
			rsp_o.valid <= sel_i;
			rsp_o.dat   <= (sel_i && !req_i.we) ? cur_word : '0;
		end
	end

endmodule

// File: hdl/wb_timer.sv
//--------------------------------------------------------------------
// Up-counting timer with compare and optional auto-reload
// Without auto-reload the count holds at compare and enable clears.
// Status bit 0 is sticky, cleared by writing 1.
//--------------------------------------------------------------------

module wb_timer (
	input  logic                   clk,
	input  logic                   rst_n_i,
	input  wb_periph_pkg::wb_req_t req_i,
	input  logic                   sel_i,
	output wb_periph_pkg::wb_rsp_t rsp_o,
	output logic                   timer_irq_o
);
	import wb_periph_pkg::*;

	logic                  en;
	logic                  auto_reload;
	logic [31:0]           cmp;
	logic [31:0]           count;
	logic                  status;
	logic                  hit;
	logic                  wr;
	logic [REG_ADDR_W-1:0] idx;
	logic [31:0]           cur_word;
	logic [31:0]           new_word;

	assign idx = req_i.adr[REG_ADDR_W+1:2];
	assign wr  = sel_i && req_i.we;
	assign hit = en && (count == cmp);

	always_comb begin
		case (idx)
			TMR_CTRL:   cur_word = {30'd0, auto_reload, en};
			TMR_CMP:    cur_word = cmp;
			TMR_COUNT:  cur_word = count;
			TMR_STATUS: cur_word = {31'd0, status};
			default:    cur_word = '0;
		endcase
	end

	assign new_word = byte_merge(cur_word, req_i.dat, req_i.sel);

	// Bus write wins over the counter in the same cycle
	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			en          <= 1'b0;
			auto_reload <= 1'b0;
			cmp         <= '0;
			count       <= '0;
			status      <= 1'b0;
		end else begin
			if (hit) begin
				status <= 1'b1;
				if (auto_reload) begin
					count <= '0;
				end else begin
					en <= 1'b0;
				end
			end else if (en) begin
				count <= count + 1'b1;
			end
			if (wr) begin
				case (idx)
					TMR_CTRL:  {auto_reload, en} <= new_word[1:0];
					TMR_CMP:   cmp <= new_word;
					TMR_COUNT: count <= new_word;
					default: begin
						// W1C on bit 0
						if (req_i.sel[0] && req_i.dat[0]) begin
							status <= 1'b0;
						end
					end
				endcase
			end
		end
	end

	assign timer_irq_o = status;

	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			rsp_o <= '0;
		end else begin
			rsp_o.valid <= sel_i;
			rsp_o.dat   <= (sel_i && !req_i.we) ? cur_word : '0;
		end
	end

endmodule

// File: hdl/wb_result.sv
//--------------------------------------------------------------------
// Result stage. Only one response is valid at a time.
// Unmapped flag is delayed once so every access acks at the same depth
//--------------------------------------------------------------------

module wb_result (
	input  logic                   clk,
	input  logic                   rst_n_i,
	input  wb_periph_pkg::wb_rsp_t pwm_rsp_i,
	input  wb_periph_pkg::wb_rsp_t tmr_rsp_i,
	input  logic                   unmapped_i,
	output logic [31:0]            wb_dat_o,
	output logic                   wb_ack_o,
	output logic                   wb_err_o
);

	// Lines up with the peripheral response cycle
	logic unmapped_q;

	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			unmapped_q <= 1'b0;
			wb_ack_o   <= 1'b0;
			wb_err_o   <= 1'b0;
			wb_dat_o   <= '0;
		end else begin
			unmapped_q <= unmapped_i;
			wb_ack_o   <= pwm_rsp_i.valid || tmr_rsp_i.valid || unmapped_q;
			wb_err_o   <= unmapped_q;
			if (pwm_rsp_i.valid) begin
				wb_dat_o <= pwm_rsp_i.dat;
			end else if (tmr_rsp_i.valid) begin
				wb_dat_o <= tmr_rsp_i.dat;
			end else begin
				wb_dat_o <= '0;
			end
		end
	end

endmodule

// File: hdl/wb_periph_top.sv
//--------------------------------------------------------------------
// Wishbone peripheral subsystem, single master, classic cycles only
// Ack comes three cycles after the accepting edge; err on unmapped
//--------------------------------------------------------------------

module wb_periph_top (
	input  logic                                   clk,
	input  logic                                   rst_n_i,
	input  logic                                   wb_cyc_i,
	input  logic                                   wb_stb_i,
	input  logic                                   wb_we_i,
	input  logic [31:0]                            wb_adr_i,
	input  logic [31:0]                            wb_dat_i,
	input  logic [3:0]                             wb_sel_i,
	output logic [31:0]                            wb_dat_o,
	output logic                                   wb_ack_o,
	output logic                                   wb_err_o,
	output logic [wb_periph_pkg::PWM_CHANNELS-1:0] pwm_o,
	output logic                                   timer_irq_o
);
	import wb_periph_pkg::*;

	wb_req_t req;
	logic    pwm_req;
	logic    tmr_req;
	logic    unmapped;
	wb_rsp_t pwm_rsp;
	wb_rsp_t tmr_rsp;

	//----------------------------------------------------------------
	// Decode
	//----------------------------------------------------------------
	wb_decoder decoder0 (
		.clk        (clk),
		.rst_n_i    (rst_n_i),
		.wb_cyc_i   (wb_cyc_i),
		.wb_stb_i   (wb_stb_i),
		.wb_we_i    (wb_we_i),
		.wb_adr_i   (wb_adr_i),
		.wb_dat_i   (wb_dat_i),
		.wb_sel_i   (wb_sel_i),
		.req_o      (req),
		.pwm_req_o  (pwm_req),
		.tmr_req_o  (tmr_req),
		.unmapped_o (unmapped)
	);

	//----------------------------------------------------------------
	// Execute
	//----------------------------------------------------------------
	wb_pwm pwm0 (
		.clk     (clk),
		.rst_n_i (rst_n_i),
		.req_i   (req),
		.sel_i   (pwm_req),
		.rsp_o   (pwm_rsp),
		.pwm_o   (pwm_o)
	);

	wb_timer timer0 (
		.clk         (clk),
		.rst_n_i     (rst_n_i),
		.req_i       (req),
		.sel_i       (tmr_req),
		.rsp_o       (tmr_rsp),
		.timer_irq_o (timer_irq_o)
	);

	// Result and acknowledge
	wb_result result0 (
		.clk        (clk),
		.rst_n_i    (rst_n_i),
		.pwm_rsp_i  (pwm_rsp),
		.tmr_rsp_i  (tmr_rsp),
		.unmapped_i (unmapped),
		.wb_dat_o   (wb_dat_o),
		.wb_ack_o   (wb_ack_o),
		.wb_err_o   (wb_err_o)
	);

endmodule

// File: verification/wb_periph_assertions.sv
//--------------------------------------------------------------------
// Bus handshake properties, bound to the subsystem top level
// Assumes a master that drops stb for a cycle after each ack
// and holds the address until ack
//--------------------------------------------------------------------

module wb_periph_assertions (
	input logic        clk,
	input logic        rst_n_i,
	input logic        wb_cyc_i,
	input logic        wb_stb_i,
	input logic [31:0] wb_adr_i,
	input logic        wb_ack_i,
	input logic        wb_err_i
);
	timeunit 1ns;
	timeprecision 1ps;
	import wb_periph_pkg::*;

	logic stb_q;
	logic start;
	logic adr_unmapped;

	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			stb_q <= 1'b0;
		end else begin
			stb_q <= wb_stb_i;
		end
	end

	// Decoder accepts on the first edge that sees stb high
	assign start = wb_cyc_i && wb_stb_i && !stb_q;

	// Address still names the slave of the pending request
	assign adr_unmapped = (wb_adr_i[31 -: SLAVE_ADDR_W] != PWM_SLAVE) &&
		(wb_adr_i[31 -: SLAVE_ADDR_W] != TIMER_SLAVE);

	ack_one_cycle: assert property (@(posedge clk) disable iff (!rst_n_i)
		wb_ack_i |=> !wb_ack_i)
		else $error("ack stayed high for more than one cycle");

	ack_after_start: assert property (@(posedge clk) disable iff (!rst_n_i)
		wb_ack_i |-> $past(start, 3))
		else $error("ack without an accepted request three cycles before");

	start_gets_ack: assert property (@(posedge clk) disable iff (!rst_n_i)
		$past(start, 3) |-> wb_ack_i)
		else $error("accepted request not acknowledged after three cycles");

	err_with_ack: assert property (@(posedge clk) disable iff (!rst_n_i)
		wb_err_i |-> wb_ack_i && adr_unmapped)
		else $error("err raised without ack or for a mapped address");

endmodule

bind wb_periph_top wb_periph_assertions assertions0 (
	.clk      (clk),
	.rst_n_i  (rst_n_i),
	.wb_cyc_i (wb_cyc_i),
	.wb_stb_i (wb_stb_i),
	.wb_adr_i (wb_adr_i),
	.wb_ack_i (wb_ack_o),
	.wb_err_i (wb_err_o)
);

// File: verification/tb_wb_periph.sv
//--------------------------------------------------------------------
// Testbench for the Wishbone peripheral subsystem
// Single master, classic cycles; random stimulus from an LCG, seed 28
// PWM count register is live and is never compared
//--------------------------------------------------------------------

module tb_wb_periph;
	timeunit 1ns;
	timeprecision 1ps;
	import wb_periph_pkg::*;

	localparam int N_RAND       = 40;
	localparam int N_UNMAPPED   = 8;
	localparam int N_PWM        = 3;
	localparam int MAX_PRESCALE = 3;
	localparam int N_TRANS = 7 + 2 * N_RAND + 2 * N_UNMAPPED + 4 + 3 * N_PWM + 8;
	localparam int TIMEOUT_CYCLES = N_TRANS * 10 + N_PWM * 256 * (MAX_PRESCALE + 1) + 2000;

	logic        clk = 1'b0;
	logic        rst_n_i;
	logic        wb_cyc_i;
	logic        wb_stb_i;
	logic        wb_we_i;
	logic [31:0] wb_adr_i;
	logic [31:0] wb_dat_i;
	logic [3:0]  wb_sel_i;
	logic [31:0] wb_dat_o;
	logic        wb_ack_o;
	logic        wb_err_o;
	logic [PWM_CHANNELS-1:0] pwm_o;
	logic        timer_irq_o;

	logic [31:0] lcg_state;
	// Register images: PWM control, duty low, duty high, timer compare
	logic [31:0] model_reg [4];
	string       reg_names [4] = '{"pwm_ctrl", "pwm_duty_lo", "pwm_duty_hi", "tmr_cmp"};
	int          errors;
	int          checks;
	int          cycle_count;

	wb_periph_top DUT (
		.clk         (clk),
		.rst_n_i     (rst_n_i),
		.wb_cyc_i    (wb_cyc_i),
		.wb_stb_i    (wb_stb_i),
		.wb_we_i     (wb_we_i),
		.wb_adr_i    (wb_adr_i),
		.wb_dat_i    (wb_dat_i),
		.wb_sel_i    (wb_sel_i),
		.wb_dat_o    (wb_dat_o),
		.wb_ack_o    (wb_ack_o),
		.wb_err_o    (wb_err_o),
		.pwm_o       (pwm_o),
		.timer_irq_o (timer_irq_o)
	);

	always #5 clk = ~clk;

	function automatic logic [31:0] rand_word();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	function automatic logic [31:0] merge_bytes(logic [31:0] old_w, logic [31:0] new_w,
		logic [3:0] sel);
		logic [31:0] mask;
		mask = {{8{sel[3]}}, {8{sel[2]}}, {8{sel[1]}}, {8{sel[0]}}};
		return (old_w & ~mask) | (new_w & mask);
	endfunction

	function automatic logic [31:0] reg_addr(logic [2:0] slave, logic [1:0] idx);
		return {slave, 25'd0, idx, 2'b00};
	endfunction

	function automatic logic [31:0] model_addr(int i);
		if (i == 3) begin
			return reg_addr(TIMER_SLAVE, TMR_CMP);
		end
		return reg_addr(PWM_SLAVE, i[1:0]);
	endfunction

	task automatic expect_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		checks++;
		assert (got === exp) else begin
			errors++;
			$display("MISMATCH %s: got 0x%08h expected 0x%08h", name, got, exp);
		end
	endtask

	// One classic cycle; stb held until ack, then dropped
	task automatic wb_transfer(input logic we, input logic [31:0] adr, input logic [31:0] dat,
		input logic [3:0] sel, output logic [31:0] rdat, output logic err);
		int lat;
		@(posedge clk);
		wb_cyc_i <= 1'b1;
		wb_stb_i <= 1'b1;
		wb_we_i  <= we;
		wb_adr_i <= adr;
		wb_dat_i <= dat;
		wb_sel_i <= sel;
		lat = -1;
		do begin
			@(posedge clk);
			lat++;
		end while (!wb_ack_o);
		rdat = wb_dat_o;
		err  = wb_err_o;
		wb_cyc_i <= 1'b0;
		wb_stb_i <= 1'b0;
		expect_value("ack_latency", lat, 32'd3);
	endtask

	task automatic write_reg(input logic [31:0] adr, input logic [31:0] dat,
		input logic [3:0] sel);
		logic [31:0] rdat;
		logic        err;
		wb_transfer(1'b1, adr, dat, sel, rdat, err);
		expect_value("wb_err_o", {31'd0, err}, 32'd0);
	endtask

	task automatic read_reg(input logic [31:0] adr, input logic [31:0] exp, input string name);
		logic [31:0] rdat;
		logic        err;
		wb_transfer(1'b0, adr, 32'd0, 4'hF, rdat, err);
		expect_value("wb_err_o", {31'd0, err}, 32'd0);
		expect_value(name, rdat, exp);
	endtask

	task automatic check_model_regs();
		for (int i = 0; i < 4; i++) begin
			read_reg(model_addr(i), model_reg[i], reg_names[i]);
		end
	endtask

	task automatic run_pwm_window();
		pwm_word_u   ctrl_w;
		pwm_word_u   lo_w;
		pwm_word_u   hi_w;
		logic [PWM_CHANNELS-1:0][DUTY_W-1:0] duties;
		logic [31:0] r;
		int          steps;
		int          want;
		int          high_cnt [PWM_CHANNELS];
		r = rand_word();
		lo_w = rand_word();
		hi_w = rand_word();
		ctrl_w.ctrl = '{rsvd: 8'h00, prescale: {14'd0, r[9:8]}, enable: r[7:0]};
		duties = {hi_w.duty, lo_w.duty};
		write_reg(reg_addr(PWM_SLAVE, PWM_DUTY_LO), lo_w, 4'hF);
		write_reg(reg_addr(PWM_SLAVE, PWM_DUTY_HI), hi_w, 4'hF);
		write_reg(reg_addr(PWM_SLAVE, PWM_CTRL), ctrl_w, 4'hF);
		model_reg[0] = ctrl_w;
		model_reg[1] = lo_w;
		model_reg[2] = hi_w;
		// Let the prescaler and the registered outputs settle
		repeat (4) @(posedge clk);
		steps = 256 * (int'(ctrl_w.ctrl.prescale) + 1);
		for (int k = 0; k < PWM_CHANNELS; k++) begin
			high_cnt[k] = 0;
		end
		repeat (steps) begin
			@(posedge clk);
			for (int k = 0; k < PWM_CHANNELS; k++) begin
				if (pwm_o[k]) begin
					high_cnt[k]++;
				end
			end
		end
		for (int k = 0; k < PWM_CHANNELS; k++) begin
			want = ctrl_w.ctrl.enable[k] ?
				int'(duties[k]) * (int'(ctrl_w.ctrl.prescale) + 1) : 0;
			expect_value($sformatf("pwm_o[%0d] high count", k), high_cnt[k], want);
		end
	endtask

	task automatic run_timer_irq();
		logic [31:0] r;
		int          cmp;
		int          waited;
		r = rand_word();
		cmp = 20 + int'(r[5:0]);
		write_reg(reg_addr(TIMER_SLAVE, TMR_CMP), cmp, 4'hF);
		model_reg[3] = cmp;
		write_reg(reg_addr(TIMER_SLAVE, TMR_COUNT), 32'd0, 4'hF);
		// Enable with auto-reload off
		write_reg(reg_addr(TIMER_SLAVE, TMR_CTRL), 32'd1, 4'hF);
		waited = 0;
		while (!timer_irq_o && waited < cmp + 10) begin
			@(posedge clk);
			waited++;
		end
		checks++;
		assert (timer_irq_o) else begin
			errors++;
			$display("timer_irq_o did not rise within %0d cycles of enabling", cmp + 10);
		end
		read_reg(reg_addr(TIMER_SLAVE, TMR_STATUS), 32'd1, "tmr_status");
		read_reg(reg_addr(TIMER_SLAVE, TMR_CTRL), 32'd0, "tmr_ctrl");
		read_reg(reg_addr(TIMER_SLAVE, TMR_COUNT), cmp, "tmr_count");
		write_reg(reg_addr(TIMER_SLAVE, TMR_STATUS), 32'd1, 4'b0001);
		expect_value("timer_irq_o", {31'd0, timer_irq_o}, 32'd0);
		read_reg(reg_addr(TIMER_SLAVE, TMR_STATUS), 32'd0, "tmr_status");
	endtask

	//----------------------------------------------------------------
	// Test sequence
	//----------------------------------------------------------------
	initial begin
		logic [31:0] r;
		logic [31:0] d;
		logic [31:0] rd;
		logic [3:0]  s;
		logic        err;
		int          t;
		lcg_state = 32'd28;
		for (int i = 0; i < 4; i++) begin
			model_reg[i] = 32'd0;
		end
		rst_n_i  <= 1'b0;
		wb_cyc_i <= 1'b0;
		wb_stb_i <= 1'b0;
		wb_we_i  <= 1'b0;
		wb_adr_i <= 32'd0;
		wb_dat_i <= 32'd0;
		wb_sel_i <= 4'd0;
		repeat (4) @(posedge clk);
		rst_n_i <= 1'b1;
		@(posedge clk);

		// Reset values
		expect_value("wb_ack_o", {31'd0, wb_ack_o}, 32'd0);
		expect_value("wb_err_o", {31'd0, wb_err_o}, 32'd0);
		expect_value("pwm_o", {24'd0, pwm_o}, 32'd0);
		expect_value("timer_irq_o", {31'd0, timer_irq_o}, 32'd0);
		check_model_regs();
		read_reg(reg_addr(TIMER_SLAVE, TMR_CTRL), 32'd0, "tmr_ctrl");
		read_reg(reg_addr(TIMER_SLAVE, TMR_COUNT), 32'd0, "tmr_count");
		read_reg(reg_addr(TIMER_SLAVE, TMR_STATUS), 32'd0, "tmr_status");

		// Random byte-masked writes with read-back
		for (int n = 0; n < N_RAND; n++) begin
			r = rand_word();
			d = rand_word();
			t = int'(r[1:0]);
			s = r[7:4];
			write_reg(model_addr(t), d, s);
			model_reg[t] = merge_bytes(model_reg[t], d, s);
			if (t == 0) begin
				// Reserved control byte reads zero
				model_reg[0][31:24] = 8'h00;
			end
			read_reg(model_addr(t), model_reg[t], reg_names[t]);
		end

		// Unmapped slave fields
		for (int n = 0; n < N_UNMAPPED; n++) begin
			r = rand_word();
			while (r[31:29] == PWM_SLAVE || r[31:29] == TIMER_SLAVE) begin
				r[31:29] = r[31:29] + 3'd1;
			end
			d = rand_word();
			wb_transfer(1'b1, r, d, 4'hF, rd, err);
			expect_value("wb_err_o", {31'd0, err}, 32'd1);
			wb_transfer(1'b0, r, d, 4'hF, rd, err);
			expect_value("wb_err_o", {31'd0, err}, 32'd1);
			expect_value("wb_dat_o", rd, 32'd0);
		end
		check_model_regs();

		for (int n = 0; n < N_PWM; n++) begin
			run_pwm_window();
		end
		run_timer_irq();

		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			$display("Timeout after %0d cycles, checks: %0d, errors: %0d", cycle_count,
				checks, errors);
			$display("Test failures found");
			$finish;
		end
	end

endmodule

// File: list.f
hdl/wb_periph_pkg.sv
hdl/wb_decoder.sv
hdl/wb_pwm.sv
hdl/wb_timer.sv
hdl/wb_result.sv
hdl/wb_periph_top.sv
verification/wb_periph_assertions.sv
verification/tb_wb_periph.sv

// File: run_sim.sh
#!/bin/sh
# Builds the Wishbone peripheral testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f list.f --top-module tb_wb_periph -o sim_wb_periph

# The log decides pass or fail, so a stopped simulation is not fatal here
./obj_dir/sim_wb_periph > sim.log 2>&1 || true
cat sim.log

if grep -q "All tests passed!" sim.log; then
	echo "Simulation passed"
else
	echo "Simulation failed"
	exit 1
fi
